// File: logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// data path and pc width.
`define DATA_W 32

// register specifier width.
`define REG_ADDR_W 5

// one-hot alu operation width.
`define ALU_OP_W 12

`define NUM_REGS 32

`endif

// File: logic/decode_pkg.sv
package decode_pkg;

    `include "decode_config.svh"

    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;

    // bit positions in alu_op_t.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        data_t inst;
        data_t pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        load_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_8;
        logic        reg_we;
        logic        mem_we;
        reg_addr_t   dest;
        logic [15:0] imm;
        data_t       rs_value;
        data_t       rt_value;
        data_t       pc;
    } issue_pkt_t;

    typedef struct packed {
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_8;
        logic      reg_we;
        logic      mem_we;
        logic      is_beq;
        logic      is_bne;
        logic      is_jal;
        logic      is_jr;
        logic      rs_used;
        logic      rt_used;
        reg_addr_t rs;
        reg_addr_t rt;
    } ctrl_t;

endpackage

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_pkt_t in_pkt,
    output logic       out_valid,
    input  logic       out_ready,
    output issue_pkt_t out_pkt,
    input  logic       wb_we,
    input  reg_addr_t  wb_addr,
    input  data_t      wb_data,
    input  logic       es_we,
    input  reg_addr_t  es_dest,
    input  logic       es_fwd_valid,
    input  data_t      es_fwd_data,
    input  logic       ms_we,
    input  reg_addr_t  ms_dest,
    input  logic       ms_fwd_valid,
    input  data_t      ms_fwd_data,
    input  logic       ws_we,
    input  reg_addr_t  ws_dest,
    input  logic       ws_fwd_valid,
    input  data_t      ws_fwd_data,
    output logic       br_valid,
    output logic       br_taken,
    output data_t      br_target
);
    logic        ds_valid;
    fetch_pkt_t  ds_pkt;
    ctrl_t       ctrl;
    alu_op_t     alu_op;
    reg_addr_t   dest;
    data_t       rf_rdata1;
    data_t       rf_rdata2;
    data_t       rs_value;
    data_t       rt_value;
    data_t       pc_plus4;
    logic        stall;
    logic        rs_eq_rt;
    logic [15:0] imm;
    logic [25:0] jidx;

    assign imm  = ds_pkt.inst[15:0];
    assign jidx = ds_pkt.inst[25:0];

    // accept when empty, or when leaving this cycle.
    assign in_ready  = !ds_valid || (!stall && out_ready);
    assign out_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (in_ready) begin
            ds_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ds_pkt <= in_pkt;
        end
    end

    inst_decoder i_decoder (
        .inst   (ds_pkt.inst),
        .ctrl   (ctrl),
        .alu_op (alu_op),
        .dest   (dest)
    );

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rs),
        .raddr2 (ctrl.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    hazard_unit i_hazard (
        .rs           (ctrl.rs),
        .rt           (ctrl.rt),
        .rs_used      (ctrl.rs_used),
        .rt_used      (ctrl.rt_used),
        .es_we        (es_we),
        .ms_we        (ms_we),
        .ws_we        (ws_we),
        .es_dest      (es_dest),
        .ms_dest      (ms_dest),
        .ws_dest      (ws_dest),
        .es_fwd_valid (es_fwd_valid),
        .ms_fwd_valid (ms_fwd_valid),
        .ws_fwd_valid (ws_fwd_valid),
        .es_fwd_data  (es_fwd_data),
        .ms_fwd_data  (ms_fwd_data),
        .ws_fwd_data  (ws_fwd_data),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .stall        (stall)
    );

    always_comb begin
        out_pkt.alu_op      = alu_op;
        out_pkt.load_op     = ctrl.load_op;
        out_pkt.src1_is_sa  = ctrl.src1_is_sa;
        out_pkt.src1_is_pc  = ctrl.src1_is_pc;
        out_pkt.src2_is_imm = ctrl.src2_is_imm;
        out_pkt.src2_is_8   = ctrl.src2_is_8;
        out_pkt.reg_we      = ctrl.reg_we;
        out_pkt.mem_we      = ctrl.mem_we;
        out_pkt.dest        = dest;
        out_pkt.imm         = imm;
        out_pkt.rs_value    = rs_value;
        out_pkt.rt_value    = rt_value;
        out_pkt.pc          = ds_pkt.pc;
    end

    // one redirect per branch, on the handoff cycle.
    assign pc_plus4 = ds_pkt.pc + data_t'(4);
    assign rs_eq_rt = (rs_value == rt_value);
    assign br_valid = out_valid && out_ready
                   && (ctrl.is_beq || ctrl.is_bne || ctrl.is_jal || ctrl.is_jr);
    assign br_taken = br_valid && ((ctrl.is_beq && rs_eq_rt) || (ctrl.is_bne && !rs_eq_rt)
                                   || ctrl.is_jal || ctrl.is_jr);

    assign br_target = (ctrl.is_beq || ctrl.is_bne) ?
                           pc_plus4 + {{14{imm[15]}}, imm, 2'b00} :
                       ctrl.is_jr ? rs_value :
                                    {pc_plus4[31:28], jidx, 2'b00};

endmodule

// File: logic/decode_top.sv
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  data_t       fetch_inst,
    input  data_t       fetch_pc,
    output logic        issue_valid,
    input  logic        issue_ready,
    output alu_op_t     issue_alu_op,
    output logic        issue_load_op,
    output logic        issue_src1_is_sa,
    output logic        issue_src1_is_pc,
    output logic        issue_src2_is_imm,
    output logic        issue_src2_is_8,
    output logic        issue_reg_we,
    output logic        issue_mem_we,
    output reg_addr_t   issue_dest,
    output logic [15:0] issue_imm,
    output data_t       issue_rs_value,
    output data_t       issue_rt_value,
    output data_t       issue_pc,
    input  logic        wb_we,
    input  reg_addr_t   wb_addr,
    input  data_t       wb_data,
    input  logic        es_we,
    input  reg_addr_t   es_dest,
    input  logic        es_fwd_valid,
    input  data_t       es_fwd_data,
    input  logic        ms_we,
    input  reg_addr_t   ms_dest,
    input  logic        ms_fwd_valid,
    input  data_t       ms_fwd_data,
    input  logic        ws_we,
    input  reg_addr_t   ws_dest,
    input  logic        ws_fwd_valid,
    input  data_t       ws_fwd_data,
    output logic        br_valid,
    output logic        br_taken,
    output data_t       br_target
);
    fetch_pkt_t fetch_pkt;
    fetch_pkt_t ds_in_pkt;
    logic       ds_in_valid;
    logic       ds_in_ready;
    issue_pkt_t ds_out_pkt;
    logic       ds_out_valid;
    logic       ds_out_ready;
    issue_pkt_t issue_pkt;

    assign fetch_pkt.inst = fetch_inst;
    assign fetch_pkt.pc   = fetch_pc;

    pipe_slice #(.payload_t(fetch_pkt_t)) i_in_slice (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (fetch_pkt),
        .out_valid (ds_in_valid),
        .out_ready (ds_in_ready),
        .out_data  (ds_in_pkt)
    );

    decode_stage i_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (ds_in_valid),
        .in_ready     (ds_in_ready),
        .in_pkt       (ds_in_pkt),
        .out_valid    (ds_out_valid),
        .out_ready    (ds_out_ready),
        .out_pkt      (ds_out_pkt),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .es_we        (es_we),
        .es_dest      (es_dest),
        .es_fwd_valid (es_fwd_valid),
        .es_fwd_data  (es_fwd_data),
        .ms_we        (ms_we),
        .ms_dest      (ms_dest),
        .ms_fwd_valid (ms_fwd_valid),
        .ms_fwd_data  (ms_fwd_data),
        .ws_we        (ws_we),
        .ws_dest      (ws_dest),
        .ws_fwd_valid (ws_fwd_valid),
        .ws_fwd_data  (ws_fwd_data),
        .br_valid     (br_valid),
        .br_taken     (br_taken),
        .br_target    (br_target)
    );

    pipe_slice #(.payload_t(issue_pkt_t)) i_out_slice (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ds_out_valid),
        .in_ready  (ds_out_ready),
        .in_data   (ds_out_pkt),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_pkt)
    );

    assign issue_alu_op      = issue_pkt.alu_op;
    assign issue_load_op     = issue_pkt.load_op;
    assign issue_src1_is_sa  = issue_pkt.src1_is_sa;
    assign issue_src1_is_pc  = issue_pkt.src1_is_pc;
    assign issue_src2_is_imm = issue_pkt.src2_is_imm;
    assign issue_src2_is_8   = issue_pkt.src2_is_8;
    assign issue_reg_we      = issue_pkt.reg_we;
    assign issue_mem_we      = issue_pkt.mem_we;
    assign issue_dest        = issue_pkt.dest;
    assign issue_imm         = issue_pkt.imm;
    assign issue_rs_value    = issue_pkt.rs_value;
    assign issue_rt_value    = issue_pkt.rt_value;
    assign issue_pc          = issue_pkt.pc;

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import decode_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      rs_used,
    input  logic      rt_used,
    input  logic      es_we,
    input  logic      ms_we,
    input  logic      ws_we,
    input  reg_addr_t es_dest,
    input  reg_addr_t ms_dest,
    input  reg_addr_t ws_dest,
    input  logic      es_fwd_valid,
    input  logic      ms_fwd_valid,
    input  logic      ws_fwd_valid,
    input  data_t     es_fwd_data,
    input  data_t     ms_fwd_data,
    input  data_t     ws_fwd_data,
    input  data_t     rf_rdata1,
    input  data_t     rf_rdata2,
    output data_t     rs_value,
    output data_t     rt_value,
    output logic      stall
);
    logic rs_block;
    logic rt_block;

    // returns {blocked, value}; nearest writer wins.
    function automatic logic [$bits(data_t):0] resolve(
        input reg_addr_t src,
        input logic      used,
        input data_t     rf_data
    );
        logic live;
        live = used && (src != '0);
        if (live && es_we && (es_dest == src)) begin
            resolve = {!es_fwd_valid, es_fwd_data};
        end else if (live && ms_we && (ms_dest == src)) begin
            resolve = {!ms_fwd_valid, ms_fwd_data};
        end else if (live && ws_we && (ws_dest == src)) begin
            resolve = {!ws_fwd_valid, ws_fwd_data};
        end else begin
            resolve = {1'b0, rf_data};
        end
    endfunction

    always_comb begin
        {rs_block, rs_value} = resolve(rs, rs_used, rf_rdata1);
        {rt_block, rt_value} = resolve(rt, rt_used, rf_rdata2);
    end

    assign stall = rs_block || rt_block;

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  data_t     inst,
    output ctrl_t     ctrl,
    output alu_op_t   alu_op,
    output reg_addr_t dest
);
    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  sa;
    logic       special;
    logic       r_plain;
    logic       r_shift;
    logic       inst_addu;
    logic       inst_subu;
    logic       inst_slt;
    logic       inst_sltu;
    logic       inst_and;
    logic       inst_or;
    logic       inst_xor;
    logic       inst_nor;
    logic       inst_sll;
    logic       inst_srl;
    logic       inst_sra;
    logic       inst_addiu;
    logic       inst_lui;
    logic       inst_lw;
    logic       inst_sw;
    logic       inst_beq;
    logic       inst_bne;
    logic       inst_jal;
    logic       inst_jr;
    logic       r_alu;
    logic       shift;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    // alu ops need sa zero, shifts need rs zero.
    assign special = (op == 6'h00);
    assign r_plain = special && (sa == '0);
    assign r_shift = special && (rs == '0);

    assign inst_addu  = r_plain && (func == 6'h21);
    assign inst_subu  = r_plain && (func == 6'h23);
    assign inst_slt   = r_plain && (func == 6'h2a);
    assign inst_sltu  = r_plain && (func == 6'h2b);
    assign inst_and   = r_plain && (func == 6'h24);
    assign inst_or    = r_plain && (func == 6'h25);
    assign inst_xor   = r_plain && (func == 6'h26);
    assign inst_nor   = r_plain && (func == 6'h27);
    assign inst_sll   = r_shift && (func == 6'h00);
    assign inst_srl   = r_shift && (func == 6'h02);
    assign inst_sra   = r_shift && (func == 6'h03);
    assign inst_addiu = (op == 6'h09);
    assign inst_lui   = (op == 6'h0f) && (rs == '0);
    assign inst_lw    = (op == 6'h23);
    assign inst_sw    = (op == 6'h2b);
    assign inst_beq   = (op == 6'h04);
    assign inst_bne   = (op == 6'h05);
    assign inst_jal   = (op == 6'h03);
    assign inst_jr    = r_plain && (func == 6'h08) && (rt == '0) && (rd == '0);

    assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu
                 | inst_and | inst_or | inst_xor | inst_nor;
    assign shift = inst_sll | inst_srl | inst_sra;

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        alu_op[ALU_SUB]  = inst_subu;
        alu_op[ALU_SLT]  = inst_slt;
        alu_op[ALU_SLTU] = inst_sltu;
        alu_op[ALU_AND]  = inst_and;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or;
        alu_op[ALU_XOR]  = inst_xor;
        alu_op[ALU_SLL]  = inst_sll;
        alu_op[ALU_SRL]  = inst_srl;
        alu_op[ALU_SRA]  = inst_sra;
        alu_op[ALU_LUI]  = inst_lui;
    end

    always_comb begin
        ctrl.load_op     = inst_lw;
        ctrl.src1_is_sa  = shift;
        ctrl.src1_is_pc  = inst_jal;
        ctrl.src2_is_imm = inst_addiu | inst_lui | inst_lw | inst_sw;
        ctrl.src2_is_8   = inst_jal;
        // unknown words fall out with no write.
        ctrl.reg_we      = r_alu | shift | inst_addiu | inst_lui | inst_lw | inst_jal;
        ctrl.mem_we      = inst_sw;
        ctrl.is_beq      = inst_beq;
        ctrl.is_bne      = inst_bne;
        ctrl.is_jal      = inst_jal;
        ctrl.is_jr       = inst_jr;
        ctrl.rs_used     = r_alu | inst_addiu | inst_lw | inst_sw | inst_beq | inst_bne
                         | inst_jr;
        ctrl.rt_used     = r_alu | shift | inst_sw | inst_beq | inst_bne;
        ctrl.rs          = rs;
        ctrl.rt          = rt;
    end

    assign dest = inst_jal                          ? reg_addr_t'(31) :
                  (inst_addiu | inst_lui | inst_lw) ? rt :
                                                      rd;

endmodule

// File: logic/pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     main_valid;
    logic     skid_valid;
    logic     skid_next;
    logic     load_main;
    logic     in_fire;
    payload_t main_data;
    payload_t skid_data;

    // in_ready high implies an empty skid entry.
    assign in_fire   = in_valid && in_ready;
    assign load_main = !main_valid || out_ready;
    assign skid_next = load_main ? 1'b0 : (skid_valid || in_fire);

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (load_main) begin
                main_valid <= skid_valid || in_fire;
            end
            skid_valid <= skid_next;
            in_ready   <= !skid_next;
        end
    end

    // older skid item goes out first.
    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= skid_valid ? skid_data : in_data;
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

    assign out_valid = main_valid;
    assign out_data  = main_data;

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module regfile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`DATA_W-1:0]     rdata1,
    output logic [`DATA_W-1:0]     rdata2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`DATA_W-1:0]     wdata
);
    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // r0 is never written, so mask it on read.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: sim.f
+incdir+logic
logic/decode_pkg.sv
logic/pipe_slice.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/hazard_unit.sv
logic/decode_stage.sv
logic/decode_top.sv
verification/decode_tb.sv

// File: verification/decode_patterns.txt
// kind_inst_pc_haz(es ms ws: we fv - dest)_fwdes_fwdms_fwdws_aluop_flags_dest_rs_rt_br_target
// kind 0 writes reg inst[4:0] with pc, 1 issues, 2 stalls then releases, f ends the list
0_00000001_00000005_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
0_00000002_00000007_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
0_00000003_fffffff0_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
0_00000004_00001000_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
0_00000005_80000000_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
0_00000008_00400020_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
1_00223021_00400000_000000_00000000_00000000_00000000_001_02_06_00000005_00000007_0_00000000
1_00613823_00400004_000000_00000000_00000000_00000000_002_02_07_fffffff0_00000005_0_00000000
1_0062482a_00400008_000000_00000000_00000000_00000000_004_02_09_fffffff0_00000007_0_00000000
1_0062502b_0040000c_000000_00000000_00000000_00000000_008_02_0a_fffffff0_00000007_0_00000000
1_00225824_00400010_000000_00000000_00000000_00000000_010_02_0b_00000005_00000007_0_00000000
1_00226025_00400014_000000_00000000_00000000_00000000_040_02_0c_00000005_00000007_0_00000000
1_00226826_00400018_000000_00000000_00000000_00000000_080_02_0d_00000005_00000007_0_00000000
1_00227027_0040001c_000000_00000000_00000000_00000000_020_02_0e_00000005_00000007_0_00000000
1_00027900_00400020_000000_00000000_00000000_00000000_100_22_0f_00000000_00000007_0_00000000
1_00058042_00400024_000000_00000000_00000000_00000000_200_22_10_00000000_80000000_0_00000000
1_00058883_00400028_000000_00000000_00000000_00000000_400_22_11_00000000_80000000_0_00000000
1_2424fffc_0040002c_000000_00000000_00000000_00000000_001_0a_04_00000005_00001000_0_00000000
1_3c031234_00400030_000000_00000000_00000000_00000000_800_0a_03_00000000_fffffff0_0_00000000
1_8c820008_00400034_000000_00000000_00000000_00000000_001_4a_02_00001000_00000007_0_00000000
1_ac81fff8_00400038_000000_00000000_00000000_00000000_001_09_1f_00001000_00000005_0_00000000
1_fc000000_0040003c_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000
1_00223021_00400040_c1c1c2_aaaa0001_bbbb0001_cccc0002_001_02_06_aaaa0001_cccc0002_0_00000000
1_00223021_00400044_c5c2c2_12345678_dddd0002_eeee0002_001_02_06_00000005_dddd0002_0_00000000
1_2424fffc_00400048_c40000_99999999_00000000_00000000_001_0a_04_00000005_00001000_0_00000000
1_00023021_0040004c_c00000_77777777_00000000_00000000_001_02_06_00000000_00000007_0_00000000
2_00223021_00400050_c10000_f00d0001_00000000_00000000_001_02_06_f00d0001_00000007_0_00000000
2_00613823_00400054_8900c3_00000000_00000000_0badc0de_002_02_07_0badc0de_00000005_0_00000000
1_10210003_00400100_000000_00000000_00000000_00000000_000_00_00_00000005_00000005_3_00400110
1_1022fffe_00400200_000000_00000000_00000000_00000000_000_00_1f_00000005_00000007_2_004001fc
1_14220010_00400300_000000_00000000_00000000_00000000_000_00_00_00000005_00000007_3_00400344
1_14210010_00400400_000000_00000000_00000000_00000000_000_00_00_00000005_00000005_2_00400444
1_0c010040_00400500_000000_00000000_00000000_00000000_001_16_1f_00000000_00000005_3_00040100
1_01000008_00400600_000000_00000000_00000000_00000000_000_00_00_00400020_00000000_3_00400020
1_01000008_00400604_c80000_00401234_00000000_00000000_000_00_00_00401234_00000000_3_00401234
f_00000000_00000000_000000_00000000_00000000_00000000_000_00_00_00000000_00000000_0_00000000

// File: verification/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;
    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 1000;

    typedef struct packed {
        logic [11:0] alu;
        logic [6:0]  flags;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] pc;
    } exp_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        fetch_valid, fetch_ready, issue_valid, issue_ready;
    logic [31:0] fetch_inst, fetch_pc;
    logic [11:0] issue_alu_op;
    logic        issue_load_op, issue_src1_is_sa, issue_src1_is_pc, issue_src2_is_imm;
    logic        issue_src2_is_8, issue_reg_we, issue_mem_we;
    logic [4:0]  issue_dest;
    logic [15:0] issue_imm;
    logic [31:0] issue_rs_value, issue_rt_value, issue_pc;
    logic        wb_we, es_we, ms_we, ws_we;
    logic [4:0]  wb_addr, es_dest, ms_dest, ws_dest;
    logic [31:0] wb_data, es_fwd_data, ms_fwd_data, ws_fwd_data;
    logic        es_fwd_valid, ms_fwd_valid, ws_fwd_valid;
    logic        br_valid, br_taken;
    logic [31:0] br_target;

    logic [315:0] pats [0:MAX_ROWS-1];
    exp_t         sb_q[$];
    logic [32:0]  br_q[$];
    integer       seed = 32'h9475f327;
    integer       rnd;
    int           errors = 0;
    int           checks = 0;
    int           in_flight = 0;
    int           fill_level = 0;
    logic         ready_before = 1'b0;
    logic         random_ready = 1'b0;
    logic         stream_phase = 1'b0;

    decode_top i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    function automatic exp_t make_exp(input logic [315:0] row);
        exp_t e;
        e.alu   = row[127:116];
        e.flags = row[114:108];
        e.dest  = row[104:100];
        // immediate passes raw from the low half of the word.
        e.imm   = row[295:280];
        e.rs    = row[99:68];
        e.rt    = row[67:36];
        e.pc    = row[279:248];
        return e;
    endfunction

    task automatic apply_hazard(input logic [315:0] row, input logic fv_on);
        es_we = row[247];
        es_fwd_valid = row[246] & fv_on;
        es_dest = row[244:240];
        ms_we = row[239];
        ms_fwd_valid = row[238] & fv_on;
        ms_dest = row[236:232];
        ws_we = row[231];
        ws_fwd_valid = row[230] & fv_on;
        ws_dest = row[228:224];
        es_fwd_data = row[223:192];
        ms_fwd_data = row[191:160];
        ws_fwd_data = row[159:128];
    endtask

    // returns on the falling edge after the handshake edge with valid still high.
    task automatic send_fetch(input logic [31:0] inst, input logic [31:0] pc);
        int t;
        t = 0;
        fetch_valid = 1'b1;
        fetch_inst = inst;
        fetch_pc = pc;
        while (!fetch_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!fetch_ready) report("fetch handshake timed out");
        @(negedge clk);
    endtask

    task automatic push_expect(input logic [315:0] row);
        sb_q.push_back(make_exp(row));
        if (row[33]) br_q.push_back({row[32], row[31:0]});
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((sb_q.size() != 0 || br_q.size() != 0) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (sb_q.size() != 0 || br_q.size() != 0) report("timed out waiting for issue");
    endtask

    task automatic run_line(input logic [315:0] row);
        exp_t nop;
        int   n;
        if (row[315:312] == 4'h0) begin
            wb_we = 1'b1;
            wb_addr = row[284:280];
            wb_data = row[279:248];
            @(negedge clk);
            wb_we = 1'b0;
        end else begin
            apply_hazard(row, row[315:312] != 4'h2);
            push_expect(row);
            send_fetch(row[311:280], row[279:248]);
            fetch_valid = 1'b0;
            if (row[315:312] == 4'h2) begin
                // sll r0,r0,0 fillers queue up behind the stalled word.
                n = 0;
                while (fetch_ready && n < 8) begin
                    nop = '0;
                    nop.alu = 12'h100;
                    nop.flags = 7'h22;
                    nop.pc = row[279:248] + 4 * (n + 1);
                    sb_q.push_back(nop);
                    send_fetch(32'h0, nop.pc);
                    fetch_valid = 1'b0;
                    n++;
                end
                if (fetch_ready) report("fetch_ready stayed high behind a stall");
                repeat (4) begin
                    @(negedge clk);
                    check_field("issue_valid", issue_valid, 1'b0);
                end
                apply_hazard(row, 1'b1);
            end
            wait_drain();
        end
    endtask

    // issue_ready changes on the falling edge and sampling waits 2 ns.
    always begin
        @(negedge clk);
        if (reset) begin
            issue_ready = 1'b0;
        end else if (random_ready) begin
            rnd = $random(seed);
            issue_ready = rnd[0];
        end else begin
            issue_ready = 1'b1;
        end
        #2;
        if (!reset && issue_valid && issue_ready) begin
            if (sb_q.size() == 0) begin
                report("issue seen with no expected packet");
            end else begin
                check_field("issue_alu_op", issue_alu_op, sb_q[0].alu);
                check_field("issue_flags", {issue_load_op, issue_src1_is_sa, issue_src1_is_pc,
                            issue_src2_is_imm, issue_src2_is_8, issue_reg_we, issue_mem_we},
                            sb_q[0].flags);
                check_field("issue_dest", issue_dest, sb_q[0].dest);
                check_field("issue_imm", issue_imm, sb_q[0].imm);
                check_field("issue_rs_value", issue_rs_value, sb_q[0].rs);
                check_field("issue_rt_value", issue_rt_value, sb_q[0].rt);
                check_field("issue_pc", issue_pc, sb_q[0].pc);
                void'(sb_q.pop_front());
            end
        end
        if (!reset && br_valid) begin
            if (br_q.size() == 0) begin
                report("br_valid raised with no branch expected");
            end else begin
                check_field("br_taken", br_taken, br_q[0][32]);
                check_field("br_target", br_target, br_q[0][31:0]);
                void'(br_q.pop_front());
            end
        end
        // fetch_ready falls on the edge that takes the fifth item.
        if (!reset && stream_phase && ready_before && !fetch_ready) begin
            check_field("items in flight", fill_level, 5);
        end
        if (!reset) begin
            fill_level = in_flight + (fetch_valid && fetch_ready);
            in_flight = fill_level - (issue_valid && issue_ready);
        end
        ready_before = fetch_ready;
    end

    initial begin
        #2_000_000;
        $display("simulation watchdog expired");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int i;
        int base;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst = '0;
        fetch_pc = '0;
        issue_ready = 1'b0;
        wb_we = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        apply_hazard('0, 1'b0);
        $readmemh("verification/decode_patterns.txt", pats);
        repeat (10) @(negedge clk);
        reset = 1'b0;
        base = errors;
        check_field("issue_valid", issue_valid, 1'b0);
        check_field("br_valid", br_valid, 1'b0);
        check_field("fetch_ready", fetch_ready, 1'b0);
        @(negedge clk);
        check_field("fetch_ready", fetch_ready, 1'b1);
        $display("test reset_state done, %0d errors", errors - base);

        base = errors;
        for (i = 0; i < MAX_ROWS && pats[i][315:312] !== 4'hf; i++) begin
            run_line(pats[i]);
        end
        $display("test directed_decode done, %0d errors", errors - base);

        // hazard-free rows again back to back under random issue_ready.
        base = errors;
        stream_phase = 1'b1;
        random_ready = 1'b1;
        apply_hazard('0, 1'b0);
        for (i = 0; i < MAX_ROWS && pats[i][315:312] !== 4'hf; i++) begin
            if (pats[i][315:312] == 4'h1 && pats[i][247:224] == 24'h0) begin
                push_expect(pats[i]);
                send_fetch(pats[i][311:280], pats[i][279:248]);
            end
        end
        fetch_valid = 1'b0;
        wait_drain();
        stream_phase = 1'b0;
        $display("test back_pressure_stream done, %0d errors", errors - base);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
